/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= requant_unit_tb
FILELIST ?= requant_unit.f
OBJ_DIR ?= obj_dir
PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* requant_unit.f */
rtl/quant_pkg.sv
rtl/apb_map_pkg.sv
rtl/coeff_bank.sv
rtl/output_scaler.sv
rtl/output_scaler_set.sv
rtl/scaler_apb_regs.sv
rtl/requant_unit.sv
verification/requant_unit_sva.sv
verification/requant_unit_tb.sv

/* rtl/apb_map_pkg.sv */
package apb_map_pkg;

    // Bus widths
    localparam int APB_AW = 12;
    localparam int APB_DW = 32;

    typedef logic [APB_AW-1:0] apb_addr_t;
    typedef logic [APB_DW-1:0] apb_data_t;

    // Register offsets
    localparam apb_addr_t REG_CFG = 12'h000;
    localparam apb_addr_t REG_SCALE = 12'h004;
    localparam apb_addr_t REG_SHIFT = 12'h008;
    localparam apb_addr_t REG_OFFSET = 12'h00C;
    localparam apb_addr_t REG_BIAS = 12'h010;
    localparam apb_addr_t REG_REWIND = 12'h014;

    // Configuration register fields
    localparam int CFG_UNSIGNED_BIT = 0;
    // Low bit of the 4-bit output width field
    localparam int CFG_OBITS_LSB = 4;

endpackage

/* rtl/coeff_bank.sv */
module coeff_bank
    import quant_pkg::*;
#(
    parameter type entry_t = logic [7:0]
) (
    input  logic   clk,
    input  logic   nrst,
    input  logic   we_i,
    input  entry_t wdata_i,
    input  logic   rewind_i,
    output entry_t coeff_o [NUM_LANES]
);

    logic [LANE_AW-1:0] ptr_q;
    logic [LANE_AW-1:0] ptr_next;

    // Wrap back to lane 0 after the last lane
    assign ptr_next = (ptr_q == LANE_AW'(NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ptr_q <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                coeff_o[i] <= '0;
            end
        end else if (rewind_i) begin
            // Rewind wins over a write in the same cycle
            ptr_q <= '0;
        end else if (we_i) begin
            coeff_o[ptr_q] <= wdata_i;
            ptr_q <= ptr_next;
        end
    end

endmodule

/* rtl/output_scaler.sv */
module output_scaler
    import quant_pkg::*;
(
    input  logic    clk,
    input  logic    nrst,
    input  wx_t     wx_i,
    input  bias_t   bias_i,
    input  scale_t  scale_i,
    input  shift_t  shift_i,
    input  offset_t offset_i,
    input  logic    cfg_unsigned_i,
    input  obits_t  cfg_obits_i,
    output y_t      y_o
);

    sum_t  sum_q;
    prod_t prod_q;
    res_t  res_d;
    res_t  hi;
    res_t  lo;
    y_t    y_d;

    // Stage 1 adds the bias
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sum_q <= '0;
        end else begin
            sum_q <= sum_t'(wx_i) + sum_t'(bias_i);
        end
    end

    // Stage 2 applies the scale
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            prod_q <= '0;
        end else begin
            prod_q <= prod_t'(sum_q) * prod_t'(scale_i);
        end
    end

    // Clamp limits for the configured width
    always_comb begin
        int n;
        n = int'(cfg_obits_i);
        // Zero or anything wider than the byte means full width
        if (n == 0 || n > OUT_W) begin
            n = OUT_W;
        end
        if (cfg_unsigned_i) begin
            hi = (res_t'(1) <<< n) - res_t'(1);
            lo = '0;
        end else begin
            hi = (res_t'(1) <<< (n - 1)) - res_t'(1);
            lo = -(res_t'(1) <<< (n - 1));
        end
    end

    // Floor shift, offset, then saturate
    always_comb begin
        res_d = (res_t'(prod_q) >>> shift_i) + res_t'(offset_i);
        if (res_d > hi) begin
            y_d = hi[OUT_W-1:0];
        end else if (res_d < lo) begin
            y_d = lo[OUT_W-1:0];
        end else begin
            // Low byte already holds the zero or sign extension
            y_d = res_d[OUT_W-1:0];
        end
    end

    // Stage 3 registers the output byte
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            y_o <= '0;
        end else begin
            y_o <= y_d;
        end
    end

endmodule

/* rtl/output_scaler_set.sv */
module output_scaler_set
    import quant_pkg::*;
    import apb_map_pkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  in_valid_i,
    input  wx_t [NUM_LANES-1:0]   wx_i,
    output logic                  out_valid_o,
    output y_t  [NUM_LANES-1:0]   y_o,
    input  logic                  scale_we_i,
    input  logic                  shift_we_i,
    input  logic                  offset_we_i,
    input  logic                  bias_we_i,
    input  apb_data_t             wdata_i,
    input  logic                  rewind_i,
    input  logic                  cfg_unsigned_i,
    input  obits_t                cfg_obits_i
);

    scale_t  scale_c  [NUM_LANES];
    shift_t  shift_c  [NUM_LANES];
    offset_t offset_c [NUM_LANES];
    bias_t   bias_c   [NUM_LANES];

    logic [LATENCY-1:0]  valid_q;
    y_t [NUM_LANES-1:0]  y_s;
    y_t [NUM_LANES-1:0]  y_hold_q;

    // One bank per coefficient kind, all rewound together
    coeff_bank #(.entry_t(scale_t)) scale_bank_i (
        .clk(clk),
        .nrst(nrst),
        .we_i(scale_we_i),
        .wdata_i(scale_t'(wdata_i[SCALE_W-1:0])),
        .rewind_i(rewind_i),
        .coeff_o(scale_c)
    );

    coeff_bank #(.entry_t(shift_t)) shift_bank_i (
        .clk(clk),
        .nrst(nrst),
        .we_i(shift_we_i),
        .wdata_i(shift_t'(wdata_i[SHIFT_W-1:0])),
        .rewind_i(rewind_i),
        .coeff_o(shift_c)
    );

    coeff_bank #(.entry_t(offset_t)) offset_bank_i (
        .clk(clk),
        .nrst(nrst),
        .we_i(offset_we_i),
        .wdata_i(offset_t'(wdata_i[OFFSET_W-1:0])),
        .rewind_i(rewind_i),
        .coeff_o(offset_c)
    );

    coeff_bank #(.entry_t(bias_t)) bias_bank_i (
        .clk(clk),
        .nrst(nrst),
        .we_i(bias_we_i),
        .wdata_i(bias_t'(wdata_i[BIAS_W-1:0])),
        .rewind_i(rewind_i),
        .coeff_o(bias_c)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        output_scaler scaler_i (
            .clk(clk),
            .nrst(nrst),
            .wx_i(wx_i[i]),
            .bias_i(bias_c[i]),
            .scale_i(scale_c[i]),
            .shift_i(shift_c[i]),
            .offset_i(offset_c[i]),
            .cfg_unsigned_i(cfg_unsigned_i),
            .cfg_obits_i(cfg_obits_i),
            .y_o(y_s[i])
        );
    end

    // Marks which pipeline slots carry a real vector
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[LATENCY-2:0], in_valid_i};
        end
    end

    assign out_valid_o = valid_q[LATENCY-1];

    // Keep the last valid vector on the output between vectors
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            y_hold_q <= '0;
        end else if (out_valid_o) begin
            y_hold_q <= y_s;
        end
    end

    assign y_o = out_valid_o ? y_s : y_hold_q;

endmodule

/* rtl/quant_pkg.sv */
package quant_pkg;

    // Lane geometry
    localparam int NUM_LANES = 8;
    localparam int LANE_AW = 3;

    // Stream widths
    localparam int WX_W = 20;
    localparam int OUT_W = 8;

    // Coefficient widths
    localparam int SCALE_W = 16;
    localparam int SHIFT_W = 4;
    localparam int OFFSET_W = 8;
    localparam int BIAS_W = 32;
    localparam int OBITS_W = 4;

    // Register stages from accumulator to output byte
    localparam int LATENCY = 3;

    // Intermediate widths, sized so that no step can overflow
    localparam int SUM_W = ((WX_W > BIAS_W) ? WX_W : BIAS_W) + 1;
    localparam int PROD_W = SUM_W + SCALE_W;
    localparam int RES_W = PROD_W + 1;

    // Stream words
    typedef logic signed [WX_W-1:0] wx_t;
    typedef logic signed [OUT_W-1:0] y_t;

    // Per-lane coefficients
    typedef logic signed [SCALE_W-1:0] scale_t;
    typedef logic [SHIFT_W-1:0] shift_t;
    typedef logic signed [OFFSET_W-1:0] offset_t;
    typedef logic signed [BIAS_W-1:0] bias_t;
    typedef logic [OBITS_W-1:0] obits_t;

    // Pipeline internals
    typedef logic signed [SUM_W-1:0] sum_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [RES_W-1:0] res_t;

endpackage

/* rtl/requant_unit.sv */
module requant_unit
    import quant_pkg::*;
    import apb_map_pkg::*;
(
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  apb_addr_t            paddr_i,
    input  apb_data_t            pwdata_i,
    output apb_data_t            prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    input  logic                 in_valid_i,
    input  wx_t [NUM_LANES-1:0]  wx_i,
    output logic                 out_valid_o,
    output y_t  [NUM_LANES-1:0]  y_o
);

    logic      scale_we;
    logic      shift_we;
    logic      offset_we;
    logic      bias_we;
    logic      rewind;
    logic      cfg_unsigned;
    obits_t    cfg_obits;
    apb_data_t wdata;

    scaler_apb_regs apb_regs_i (
        .clk(clk),
        .nrst(nrst),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .paddr_i(paddr_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .scale_we_o(scale_we),
        .shift_we_o(shift_we),
        .offset_we_o(offset_we),
        .bias_we_o(bias_we),
        .wdata_o(wdata),
        .rewind_o(rewind),
        .cfg_unsigned_o(cfg_unsigned),
        .cfg_obits_o(cfg_obits)
    );

    output_scaler_set scaler_set_i (
        .clk(clk),
        .nrst(nrst),
        .in_valid_i(in_valid_i),
        .wx_i(wx_i),
        .out_valid_o(out_valid_o),
        .y_o(y_o),
        .scale_we_i(scale_we),
        .shift_we_i(shift_we),
        .offset_we_i(offset_we),
        .bias_we_i(bias_we),
        .wdata_i(wdata),
        .rewind_i(rewind),
        .cfg_unsigned_i(cfg_unsigned),
        .cfg_obits_i(cfg_obits)
    );

endmodule

/* rtl/scaler_apb_regs.sv */
module scaler_apb_regs
    import quant_pkg::*;
    import apb_map_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    output logic      scale_we_o,
    output logic      shift_we_o,
    output logic      offset_we_o,
    output logic      bias_we_o,
    output apb_data_t wdata_o,
    output logic      rewind_o,
    output logic      cfg_unsigned_o,
    output obits_t    cfg_obits_o
);

    logic   access;
    logic   wr;
    logic   mapped;
    logic   hit_cfg;
    logic   hit_scale;
    logic   hit_shift;
    logic   hit_offset;
    logic   hit_bias;
    logic   hit_rewind;
    logic   cfg_unsigned_q;
    obits_t cfg_obits_q;

    // Address decode
    assign hit_cfg = (paddr_i == REG_CFG);
    assign hit_scale = (paddr_i == REG_SCALE);
    assign hit_shift = (paddr_i == REG_SHIFT);
    assign hit_offset = (paddr_i == REG_OFFSET);
    assign hit_bias = (paddr_i == REG_BIAS);
    assign hit_rewind = (paddr_i == REG_REWIND);
    assign mapped = hit_cfg | hit_scale | hit_shift | hit_offset | hit_bias | hit_rewind;

    // Zero wait states, so the access phase is always one cycle
    assign access = psel_i && penable_i;
    assign wr = access && pwrite_i && mapped;
    assign pready_o = 1'b1;
    assign pslverr_o = access && !mapped;

    // Data port pulses, one per write
    assign scale_we_o = wr && hit_scale;
    assign shift_we_o = wr && hit_shift;
    assign offset_we_o = wr && hit_offset;
    assign bias_we_o = wr && hit_bias;
    assign rewind_o = wr && hit_rewind;
    assign wdata_o = pwdata_i;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cfg_unsigned_q <= 1'b0;
            cfg_obits_q <= '0;
        end else if (wr && hit_cfg) begin
            cfg_unsigned_q <= pwdata_i[CFG_UNSIGNED_BIT];
            cfg_obits_q <= pwdata_i[CFG_OBITS_LSB +: OBITS_W];
        end
    end

    assign cfg_unsigned_o = cfg_unsigned_q;
    assign cfg_obits_o = cfg_obits_q;

    // Only the configuration register reads back
    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i && hit_cfg) begin
            prdata_o[CFG_UNSIGNED_BIT] = cfg_unsigned_q;
            prdata_o[CFG_OBITS_LSB +: OBITS_W] = cfg_obits_q;
        end
    end

endmodule

/* verification/requant_unit_sva.sv */
module requant_unit_sva
    import quant_pkg::*;
(
    input logic clk,
    input logic nrst,
    input logic psel_i,
    input logic penable_i,
    input logic pready_o,
    input logic pslverr_o,
    input logic in_valid_i,
    input logic out_valid_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Output valid trails input valid by the pipeline depth
    valid_latency_a: assert property (@(posedge clk) disable iff (!nrst)
        out_valid_o == $past(in_valid_i, LATENCY))
        else $error("out_valid_o does not follow in_valid_i by %0d cycles", LATENCY);

    // Zero wait state slave
    pready_high_a: assert property (@(posedge clk) disable iff (!nrst) pready_o)
        else $error("pready_o went low");

    // Slave error only inside an access phase
    pslverr_access_a: assert property (@(posedge clk) disable iff (!nrst)
        pslverr_o |-> (psel_i && penable_i))
        else $error("pslverr_o high outside an access phase");

endmodule

bind requant_unit requant_unit_sva requant_unit_sva_i (.*);

/* verification/requant_unit_tb.sv */
module requant_unit_tb
    import quant_pkg::*;
    import apb_map_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    // Rough cycle budget per test, in test order
    localparam int TEST_CYCLES = 20 + 50 + 140 + 120 + 30 + 70;
    localparam int MARGIN_CYCLES = 200;
    localparam int APB_WAIT_LIMIT = 16;
    localparam int DRAIN_LIMIT = LATENCY + 8;

    typedef wx_t [NUM_LANES-1:0] wx_vec_t;
    typedef y_t [NUM_LANES-1:0] y_vec_t;

    logic clk = 1'b0;
    logic nrst;
    logic psel;
    logic penable;
    logic pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic pready;
    logic pslverr;
    logic in_valid;
    wx_vec_t wx;
    logic out_valid;
    y_vec_t y;

    // Reference copy of coefficients and configuration
    scale_t scale_m [NUM_LANES];
    shift_t shift_m [NUM_LANES];
    offset_t offset_m [NUM_LANES];
    bias_t bias_m [NUM_LANES];
    logic cfg_uns_m;
    obits_t cfg_obits_m;

    y_vec_t exp_q [$];
    int due_q [$];
    // Last vector that left the stream, held on y_o between vectors
    y_vec_t last_y;
    int cyc = 0;
    int err_cnt = 0;
    int check_cnt = 0;

    requant_unit requant_unit_i (
        .clk(clk),
        .nrst(nrst),
        .psel_i(psel),
        .penable_i(penable),
        .pwrite_i(pwrite),
        .paddr_i(paddr),
        .pwdata_i(pwdata),
        .prdata_o(prdata),
        .pready_o(pready),
        .pslverr_o(pslverr),
        .in_valid_i(in_valid),
        .wx_i(wx),
        .out_valid_o(out_valid),
        .y_o(y)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        err_cnt++;
    endtask

    task automatic check_y(input int lane, input y_t got, input y_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL y_o[%0d]: got 0x%h, expected 0x%h", lane, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Per-lane arithmetic rule in wide signed arithmetic
    function automatic y_t model_y(input wx_t x, input int lane);
        longint res;
        longint hi;
        longint lo;
        int n;
        res = (longint'(x) + longint'(bias_m[lane])) * longint'(scale_m[lane]);
        res = (res >>> shift_m[lane]) + longint'(offset_m[lane]);
        n = int'(cfg_obits_m);
        if (n == 0 || n > OUT_W) begin
            n = OUT_W;
        end
        if (cfg_uns_m) begin
            hi = (64'sd1 << n) - 1;
            lo = 0;
        end else begin
            hi = (64'sd1 << (n - 1)) - 1;
            lo = -(64'sd1 << (n - 1));
        end
        if (res > hi) begin
            res = hi;
        end else if (res < lo) begin
            res = lo;
        end
        return y_t'(res);
    endfunction

    function automatic apb_data_t cfg_word(input logic uns, input obits_t obits);
        apb_data_t w;
        w = '0;
        w[CFG_UNSIGNED_BIT] = uns;
        w[CFG_OBITS_LSB +: 4] = obits;
        return w;
    endfunction

    // Span 0 draws from the full accumulator range
    function automatic wx_vec_t random_vector(input int span);
        wx_vec_t v;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (span == 0) begin
                v[i] = wx_t'($urandom);
            end else begin
                v[i] = wx_t'(int'($urandom_range(0, 2 * span)) - span);
            end
        end
        return v;
    endfunction

    function automatic wx_vec_t const_vector(input wx_t value);
        wx_vec_t v;
        for (int i = 0; i < NUM_LANES; i++) begin
            v[i] = value;
        end
        return v;
    endfunction

    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, output apb_data_t rdata,
                                output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready && waited < APB_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            report_error("APB transfer never saw pready_o");
        end
        rdata = prdata;
        err = pslverr;
        // Access phase ends at this edge
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        logic err;
        apb_write(addr, data, err);
        check_bit("pslverr_o", err, 1'b0);
    endtask

    task automatic write_cfg(input logic uns, input obits_t obits);
        write_reg(REG_CFG, cfg_word(uns, obits));
        cfg_uns_m = uns;
        cfg_obits_m = obits;
    endtask

    // Rewind, then one write per lane on every data port
    task automatic load_lane_coeffs();
        write_reg(REG_REWIND, '0);
        for (int i = 0; i < NUM_LANES; i++) write_reg(REG_SCALE, apb_data_t'(scale_m[i]));
        for (int i = 0; i < NUM_LANES; i++) write_reg(REG_SHIFT, apb_data_t'(shift_m[i]));
        for (int i = 0; i < NUM_LANES; i++) write_reg(REG_OFFSET, apb_data_t'(offset_m[i]));
        for (int i = 0; i < NUM_LANES; i++) write_reg(REG_BIAS, apb_data_t'(bias_m[i]));
    endtask

    // Vector is sampled at the next edge and due LATENCY edges after that
    task automatic send_vector(input wx_vec_t vec);
        y_vec_t exp_vec;
        for (int i = 0; i < NUM_LANES; i++) begin
            exp_vec[i] = model_y(vec[i], i);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        wx = vec;
        exp_q.push_back(exp_vec);
        due_q.push_back(cyc + LATENCY);
    endtask

    // Idle cycles carry fresh data so that a missing hold shows on y_o
    task automatic stream_gap(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            wx = random_vector(0);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        stream_gap(1);
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_error("stream did not drain, vectors are missing at the output");
            exp_q.delete();
            due_q.delete();
        end
    endtask

    // Output checker, pops one expected vector per valid cycle
    always @(negedge clk) begin : out_monitor
        y_vec_t exp_vec;
        int due;
        if (nrst) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    report_error("out_valid_o high with no vector in flight");
                end else begin
                    exp_vec = exp_q.pop_front();
                    due = due_q.pop_front();
                    if (due != cyc) begin
                        report_error($sformatf("vector due at cycle %0d came out at cycle %0d",
                                               due, cyc));
                    end
                    for (int i = 0; i < NUM_LANES; i++) begin
                        check_y(i, y[i], exp_vec[i]);
                    end
                    last_y = exp_vec;
                end
            end else begin
                // Between vectors the output keeps the last one
                for (int i = 0; i < NUM_LANES; i++) begin
                    check_y(i, y[i], last_y[i]);
                end
                if (due_q.size() != 0 && due_q[0] <= cyc) begin
                    report_error($sformatf("vector due at cycle %0d never came out", due_q[0]));
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end
        end
    end

    task automatic reset_defaults();
        apb_data_t rd;
        logic err;
        @(negedge clk);
        check_bit("out_valid_o", out_valid, 1'b0);
        apb_read(REG_CFG, rd, err);
        check_word("prdata_o", rd, '0);
        check_bit("pslverr_o", err, 1'b0);
        send_vector(random_vector(0));
        send_vector(const_vector(wx_t'(-1)));
        wait_drain();
    endtask

    task automatic cfg_readback();
        apb_data_t vals [4] = '{32'h0000_0081, 32'h0000_0040, 32'hABCD_12F1, 32'h0};
        apb_data_t rd;
        logic err;
        for (int k = 0; k < 4; k++) begin
            write_reg(REG_CFG, vals[k]);
            apb_read(REG_CFG, rd, err);
            check_word("prdata_o", rd,
                       cfg_word(vals[k][CFG_UNSIGNED_BIT], vals[k][CFG_OBITS_LSB +: 4]));
        end
        write_cfg(1'b1, 4'd5);
        // Unmapped offsets must error and leave the configuration alone
        apb_write(12'h018, 32'h0000_0030, err);
        check_bit("pslverr_o", err, 1'b1);
        apb_write(12'h005, 32'h0000_0030, err);
        check_bit("pslverr_o", err, 1'b1);
        apb_read(12'h800, rd, err);
        check_bit("pslverr_o", err, 1'b1);
        apb_read(REG_SCALE, rd, err);
        check_word("prdata_o", rd, '0);
        check_bit("pslverr_o", err, 1'b0);
        apb_read(REG_CFG, rd, err);
        check_word("prdata_o", rd, cfg_word(1'b1, 4'd5));
    endtask

    task automatic signed_lane_coeffs();
        // Lane-dependent steps keep every coefficient distinct
        for (int i = 0; i < NUM_LANES; i++) begin
            scale_m[i] = scale_t'(i * 7 + 1 + int'($urandom_range(0, 5)));
            shift_m[i] = shift_t'(i + 4);
            offset_m[i] = offset_t'(i * 9 - 30);
            bias_m[i] = bias_t'(i * 250 - 900 + int'($urandom_range(0, 99)));
        end
        write_cfg(1'b0, 4'd8);
        load_lane_coeffs();
        send_vector(const_vector(wx_t'(-(1 << 19))));
        send_vector(const_vector(wx_t'((1 << 19) - 1)));
        repeat (10) send_vector(random_vector(0));
        repeat (10) send_vector(random_vector(300));
        wait_drain();
    endtask

    task automatic unsigned_narrow_clamp();
        logic uns_list [6] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
        obits_t n_list [6] = '{4'd8, 4'd1, 4'd4, 4'd6, 4'd4, 4'd12};
        for (int k = 0; k < 6; k++) begin
            write_cfg(uns_list[k], n_list[k]);
            send_vector(const_vector(wx_t'(-(1 << 19))));
            send_vector(const_vector(wx_t'((1 << 19) - 1)));
            repeat (3) send_vector(random_vector(0));
            repeat (3) send_vector(random_vector(300));
            wait_drain();
        end
    endtask

    task automatic back_to_back_stream();
        write_cfg(1'b0, 4'd8);
        repeat (3) send_vector(random_vector(300));
        stream_gap(1);
        repeat (2) send_vector(random_vector(0));
        stream_gap(2);
        repeat (4) send_vector(random_vector(300));
        wait_drain();
    endtask

    task automatic rewind_and_wrap();
        scale_t val;
        write_cfg(1'b0, 4'd8);
        scale_m[0] = scale_t'(300);
        scale_m[1] = scale_t'(-5);
        write_reg(REG_REWIND, '0);
        write_reg(REG_SCALE, apb_data_t'(scale_m[0]));
        write_reg(REG_SCALE, apb_data_t'(scale_m[1]));
        repeat (6) send_vector(random_vector(300));
        wait_drain();
        // Ten writes run past the last lane onto lanes 0 and 1
        write_reg(REG_REWIND, '0);
        for (int k = 0; k < NUM_LANES + 2; k++) begin
            val = scale_t'(k * 13 - 40);
            scale_m[k % NUM_LANES] = val;
            write_reg(REG_SCALE, apb_data_t'(val));
        end
        repeat (6) send_vector(random_vector(300));
        wait_drain();
    endtask

    initial begin : watchdog
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        void'($urandom(32'h7993));
        nrst = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        in_valid = 1'b0;
        wx = '0;
        last_y = '0;
        cfg_uns_m = 1'b0;
        cfg_obits_m = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            scale_m[i] = '0;
            shift_m[i] = '0;
            offset_m[i] = '0;
            bias_m[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        nrst = 1'b1;
        reset_defaults();
        cfg_readback();
        signed_lane_coeffs();
        unsigned_narrow_clamp();
        back_to_back_stream();
        rewind_and_wrap();
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
